// ==== testbench/soc_trace.txt ====
# op  master  byte_addr  data  sel  expect (hex except master, unused columns 0)
# fork runs the two lines after it together, master 0 must ack first
write       0  00000010  aabbccdd  f  0
write       1  00000010  11223344  5  0
read        0  00000010  0         f  aa22cc44
read        1  00000010  0         f  aa22cc44
fork        0  0         0         0  0
write       0  00000040  11112222  f  0
write       1  00000044  33334444  f  0
fork        0  0         0         0  0
read        1  00000040  0         f  11112222
read        0  00000044  0         f  33334444
write       0  00000000  01234567  f  0
write       1  00000300  89abcdef  f  0
read        1  00010000  0         f  0
read        0  ffff0300  0         f  0
write       0  00010000  deadbeef  f  0
write       1  ffff0300  cafef00d  f  0
read        0  00000000  0         f  01234567
read        1  00000300  0         f  89abcdef
switch      0  0         00005a3c  0  0
read        1  ffff0200  0         f  00005a3c
write       0  ffff0204  0000beef  3  0
expect-led  0  0         0         0  0000beef
read        1  ffff0204  0         f  0000beef
write       1  ffff0204  00001200  2  0
expect-led  0  0         0         0  000012ef
read        0  ffff0204  0         f  000012ef
write       0  ffff0208  1         1  0
read        0  ffff0208  0         f  0
write       1  ffff020c  1         1  0
expect-irq  0  0         0         0  0
switch      0  0         00001234  0  0
expect-irq  0  0         0         0  1
read        1  ffff0208  0         f  1
write       0  ffff0208  1         1  0
expect-irq  0  0         0         0  0
write       0  ffff020c  0         1  0
switch      0  0         00004321  0  0
expect-irq  0  0         0         0  0
read        0  ffff0208  0         f  1

// ==== verilog.f ====
logic/wb_bus_pkg.sv
logic/soc_map_pkg.sv
logic/wb_arbiter.sv
logic/wb_slave_decoder.sv
logic/wb_ram.sv
logic/dev_adapter.sv
logic/board_regs.sv
logic/soc_top.sv
testbench/tb_soc_top.sv

// ==== testbench/tb_soc_top.sv ====
`timescale 1ns/1ns

module tb_soc_top;
	import wb_bus_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int CYCLES_PER_LINE = 50;
	localparam int unsigned SEED = 32'h3ccd65bf;

	localparam int OP_WRITE = 0;
	localparam int OP_READ = 1;
	localparam int OP_SWITCH = 2;
	localparam int OP_IRQ = 3;
	localparam int OP_LED = 4;
	localparam int OP_FORK = 5;

	logic clk_cpu;
	logic rst_i;
	wb_req_t m0_req;
	wb_req_t m1_req;
	wb_rsp_t m0_rsp;
	wb_rsp_t m1_rsp;
	logic [15:0] sw;
	logic [15:0] led;
	logic irq;

	int op_q[$];
	int master_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [3:0] sel_q[$];
	logic [31:0] exp_q[$];
	time ack_time [0:1];
	int n_tests;
	int n_fail;
	logic loaded;

	soc_top i_soc_top (
		.clk_cpu (clk_cpu),
		.rst_i   (rst_i),
		.m0_req_i(m0_req),
		.m1_req_i(m1_req),
		.m0_rsp_o(m0_rsp),
		.m1_rsp_o(m1_rsp),
		.switch_i(sw),
		.led_o   (led),
		.irq_o   (irq)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;
	end

	function automatic int op_code(input logic [8*16-1:0] tok);
		case (tok)
			"write": op_code = OP_WRITE;
			"read": op_code = OP_READ;
			"switch": op_code = OP_SWITCH;
			"expect-irq": op_code = OP_IRQ;
			"expect-led": op_code = OP_LED;
			"fork": op_code = OP_FORK;
			default: op_code = -1;
		endcase
	endfunction

	function automatic string op_name(input int op);
		case (op)
			OP_WRITE: op_name = "write";
			OP_READ: op_name = "read";
			OP_SWITCH: op_name = "switch";
			OP_IRQ: op_name = "expect-irq";
			OP_LED: op_name = "expect-led";
			default: op_name = "unknown";
		endcase
	endfunction

	// comment and blank lines fail the scan and are skipped
	task automatic load_trace();
		int fd;
		int code;
		int m;
		logic [8*256-1:0] line_buf;
		logic [8*16-1:0] tok;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] s;
		logic [31:0] e;
		fd = $fopen("testbench/soc_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file testbench/soc_trace.txt");
			n_fail++;
			return;
		end
		while (!$feof(fd)) begin
			line_buf = '0;
			code = $fgets(line_buf, fd);
			code = $sscanf(line_buf, "%s %d %h %h %h %h", tok, m, a, d, s, e);
			if (code == 6) begin
				op_q.push_back(op_code(tok));
				master_q.push_back(m);
				addr_q.push_back(a);
				data_q.push_back(d);
				sel_q.push_back(s[3:0]);
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	// one transfer, held until ack
	task automatic bus_transfer(input int m, input logic we, input logic [31:0] baddr,
			input logic [31:0] wdata, input logic [3:0] sel, output logic [31:0] rdata);
		wb_req_t req;
		logic ack;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.sel = sel;
		req.addr = baddr[31:2];
		req.data = wdata;
		@(posedge clk_cpu);
		if (m == 0) m0_req <= req;
		else m1_req <= req;
		ack = 1'b0;
		while (!ack) begin
			@(negedge clk_cpu);
			ack = (m == 0) ? m0_rsp.ack : m1_rsp.ack;
			rdata = (m == 0) ? m0_rsp.data : m1_rsp.data;
		end
		ack_time[m] = $time;
		@(posedge clk_cpu);
		if (m == 0) m0_req <= '0;
		else m1_req <= '0;
	endtask

	task automatic report(input string what, input logic ok);
		n_tests++;
		if (!ok) n_fail++;
		$display("test %0d %0s: %0s", n_tests, what, ok ? "ok" : "fail");
	endtask

	task automatic run_line(input int idx);
		logic [31:0] rdata;
		logic ok;
		logic seen;
		ok = 1'b1;
		case (op_q[idx])
			OP_WRITE: begin
				bus_transfer(master_q[idx], 1'b1, addr_q[idx], data_q[idx], sel_q[idx], rdata);
			end
			OP_READ: begin
				bus_transfer(master_q[idx], 1'b0, addr_q[idx], 32'h0, sel_q[idx], rdata);
				if (rdata !== exp_q[idx]) begin
					$display("** Error at %0t ns: read %h from %h, expected %h",
						$time, rdata, addr_q[idx], exp_q[idx]);
					ok = 1'b0;
				end
			end
			OP_SWITCH: begin
				@(posedge clk_cpu);
				sw <= data_q[idx][15:0];
			end
			OP_LED: begin
				@(negedge clk_cpu);
				if (led !== exp_q[idx][15:0]) begin
					$display("** Error at %0t ns: led_o is %h, expected %h",
						$time, led, exp_q[idx][15:0]);
					ok = 1'b0;
				end
			end
			OP_IRQ: begin
				// irq must show up within 3 cycles of the switch edge
				seen = 1'b0;
				repeat (3) begin
					@(negedge clk_cpu);
					if (irq !== 1'b0) seen = 1'b1;
				end
				if (seen !== exp_q[idx][0]) begin
					$display("** Error at %0t ns: irq_o seen %b, expected %b",
						$time, seen, exp_q[idx][0]);
					ok = 1'b0;
				end
			end
			default: begin
				$display("step %0d of the trace has an unknown operation", idx);
				ok = 1'b0;
			end
		endcase
		report($sformatf("%0s m%0d %h", op_name(op_q[idx]), master_q[idx], addr_q[idx]), ok);
	endtask

	// both lines start on the same edge
	task automatic run_pair(input int idx);
		logic ok;
		fork
			run_line(idx + 1);
			run_line(idx + 2);
		join
		ok = 1'b1;
		if (ack_time[0] >= ack_time[1]) begin
			$display("** Error at %0t ns: master 1 acked at %0t, not after master 0 at %0t",
				$time, ack_time[1], ack_time[0]);
			ok = 1'b0;
		end
		report("priority order", ok);
	endtask

	initial begin
		int unsigned seed_ret;
		int i;
		rst_i = 1'b1;
		m0_req = '0;
		m1_req = '0;
		sw = '0;
		n_tests = 0;
		n_fail = 0;
		loaded = 1'b0;
		seed_ret = $urandom(SEED);
		load_trace();
		loaded = 1'b1;
		repeat (2) @(posedge clk_cpu);
		rst_i <= 1'b0;
		@(negedge clk_cpu);
		if (led !== '0 || irq !== 1'b0 || m0_rsp.ack !== 1'b0 || m1_rsp.ack !== 1'b0) begin
			$display("** Error at %0t ns: outputs not idle after reset", $time);
			report("reset state", 1'b0);
		end else begin
			report("reset state", 1'b1);
		end
		i = 0;
		while (i < op_q.size()) begin
			if (op_q[i] == OP_FORK && i + 2 < op_q.size()) begin
				run_pair(i);
				i += 3;
			end else begin
				if (op_q[i] != OP_IRQ) repeat ($urandom % 4) @(posedge clk_cpu);
				run_line(i);
				i++;
			end
		end
		$display("%0d tests, %0d passed, %0d failed", n_tests, n_tests - n_fail, n_fail);
		if (n_fail == 0 && op_q.size() > 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		repeat ((op_q.size() + 1) * CYCLES_PER_LINE) @(posedge clk_cpu);
		$display("timeout: the trace did not finish in time, a transfer never got its ack");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== logic/soc_top.sv ====
`timescale 1ns/1ns

module soc_top (
	input  logic                             clk_cpu,
	input  logic                             rst_i,
	input  wb_bus_pkg::wb_req_t              m0_req_i,
	input  wb_bus_pkg::wb_req_t              m1_req_i,
	output wb_bus_pkg::wb_rsp_t              m0_rsp_o,
	output wb_bus_pkg::wb_rsp_t              m1_rsp_o,
	input  logic [soc_map_pkg::SWITCH_W-1:0] switch_i,
	output logic [soc_map_pkg::LED_W-1:0]    led_o,
	output logic                             irq_o
);
	import wb_bus_pkg::*;

	wb_req_t bus_req;
	wb_rsp_t bus_rsp;
	wb_req_t ram_req;
	wb_rsp_t ram_rsp;
	wb_req_t dev_req;
	wb_rsp_t dev_rsp;
	dev_req_t board_req;
	wb_rsp_t board_rsp;

	wb_arbiter i_wb_arbiter (
		.clk_cpu  (clk_cpu),
		.rst_i    (rst_i),
		.m0_req_i (m0_req_i),
		.m1_req_i (m1_req_i),
		.m0_rsp_o (m0_rsp_o),
		.m1_rsp_o (m1_rsp_o),
		.bus_req_o(bus_req),
		.bus_rsp_i(bus_rsp)
	);

	wb_slave_decoder i_wb_slave_decoder (
		.clk_cpu  (clk_cpu),
		.rst_i    (rst_i),
		.bus_req_i(bus_req),
		.bus_rsp_o(bus_rsp),
		.ram_req_o(ram_req),
		.ram_rsp_i(ram_rsp),
		.dev_req_o(dev_req),
		.dev_rsp_i(dev_rsp)
	);

	wb_ram i_wb_ram (
		.clk_cpu(clk_cpu),
		.rst_i  (rst_i),
		.req_i  (ram_req),
		.rsp_o  (ram_rsp)
	);

	// device region, board in slot 2
	dev_adapter i_dev_adapter (
		.clk_cpu    (clk_cpu),
		.rst_i      (rst_i),
		.req_i      (dev_req),
		.rsp_o      (dev_rsp),
		.board_o    (board_req),
		.board_rsp_i(board_rsp)
	);

	board_regs i_board_regs (
		.clk_cpu (clk_cpu),
		.rst_i   (rst_i),
		.dev_i   (board_req),
		.rsp_o   (board_rsp),
		.switch_i(switch_i),
		.led_o   (led_o),
		.irq_o   (irq_o)
	);

endmodule

// ==== logic/board_regs.sv ====
`timescale 1ns/1ns

module board_regs (
	input  logic                             clk_cpu,
	input  logic                             rst_i,
	input  wb_bus_pkg::dev_req_t             dev_i,
	output wb_bus_pkg::wb_rsp_t              rsp_o,
	input  logic [soc_map_pkg::SWITCH_W-1:0] switch_i,
	output logic [soc_map_pkg::LED_W-1:0]    led_o,
	output logic                             irq_o
);
	import wb_bus_pkg::*;
	import soc_map_pkg::*;

	logic [SWITCH_W-1:0] sw_q;
	logic [SWITCH_W-1:0] sw_d;
	logic [LED_W-1:0] led_q;
	logic irq_status;
	logic irq_en;
	logic ack_q;
	logic [DATA_W-1:0] rdata_q;
	logic access;
	logic wr_en;
	logic sw_change;

	assign access = dev_i.cs && !ack_q;
	assign wr_en = access && dev_i.we;
	assign sw_change = (sw_q != sw_d);

	// switch sample and its previous value
	always_ff @(posedge clk_cpu) begin
		sw_q <= switch_i;
		sw_d <= sw_q;
	end

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			led_q <= '0;
			irq_en <= 1'b0;
			irq_status <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
			if (wr_en && dev_i.addr == REG_LED) begin
				for (int i = 0; i < LED_W / 8; i++) begin
					if (dev_i.sel[i]) begin
						led_q[i*8 +: 8] <= dev_i.data[i*8 +: 8];
					end
				end
			end
			if (wr_en && dev_i.addr == REG_IRQ_ENABLE && dev_i.sel[0]) begin
				irq_en <= dev_i.data[0];
			end
			// a fresh change beats a clear in the same cycle
			if (sw_change) begin
				irq_status <= 1'b1;
			end else if (wr_en && dev_i.addr == REG_IRQ_STATUS && dev_i.sel[0] && dev_i.data[0]) begin
				irq_status <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (access) begin
			case (dev_i.addr)
				REG_SWITCH: rdata_q <= DATA_W'(sw_q);
				REG_LED: rdata_q <= DATA_W'(led_q);
				REG_IRQ_STATUS: rdata_q <= DATA_W'(irq_status);
				REG_IRQ_ENABLE: rdata_q <= DATA_W'(irq_en);
				default: rdata_q <= '0;
			endcase
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.data = rdata_q;
	assign led_o = led_q;
	assign irq_o = irq_status && irq_en;

endmodule

// ==== logic/dev_adapter.sv ====
`timescale 1ns/1ns

module dev_adapter (
	input  logic                 clk_cpu,
	input  logic                 rst_i,
	input  wb_bus_pkg::wb_req_t  req_i,
	output wb_bus_pkg::wb_rsp_t  rsp_o,
	output wb_bus_pkg::dev_req_t board_o,
	input  wb_bus_pkg::wb_rsp_t  board_rsp_i
);
	import wb_bus_pkg::*;
	import soc_map_pkg::*;

	// slot index sits above the in-slot word offset
	localparam int SLOT_W = DEV_ADDR_BITS - SLOT_BITS;
	localparam int SLOT_LSB = SLOT_BITS - 2;

	logic [SLOT_W-1:0] slot;
	logic board_hit;
	logic empty_stb;
	logic empty_ack;

	assign slot = req_i.addr[SLOT_LSB +: SLOT_W];
	assign board_hit = (slot == SLOT_W'(SLOT_BOARD));
	assign empty_stb = req_i.cyc && req_i.stb && !board_hit;

	always_comb begin
		board_o.cs = req_i.cyc && req_i.stb && board_hit;
		board_o.we = req_i.we;
		board_o.sel = req_i.sel;
		board_o.addr = req_i.addr[REG_ADDR_W-1:0];
		board_o.data = req_i.data;
	end

	// nobody lives in the other slots
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			empty_ack <= 1'b0;
		end else begin
			empty_ack <= empty_stb && !empty_ack;
		end
	end

	always_comb begin
		if (board_hit) begin
			rsp_o = board_rsp_i;
		end else begin
			rsp_o.ack = empty_ack;
			rsp_o.data = '0;
		end
	end

endmodule

// ==== logic/wb_ram.sv ====
`timescale 1ns/1ns

module wb_ram (
	input  logic                clk_cpu,
	input  logic                rst_i,
	input  wb_bus_pkg::wb_req_t req_i,
	output wb_bus_pkg::wb_rsp_t rsp_o
);
	import wb_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int DEPTH = 2 ** RAM_ADDR_BITS;

	logic [DATA_W-1:0] mem [0:DEPTH-1];
	logic [RAM_ADDR_BITS-1:0] idx;
	logic access;
	logic ack_q;
	logic [DATA_W-1:0] rdata_q;

	assign idx = req_i.addr[RAM_ADDR_BITS-1:0];
	// first cycle of a transfer only
	assign access = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge clk_cpu) begin
		if (access && req_i.we) begin
			for (int i = 0; i < SEL_W; i++) begin
				if (req_i.sel[i]) begin
					mem[idx][i*8 +: 8] <= req_i.data[i*8 +: 8];
				end
			end
		end
		if (access) begin
			rdata_q <= mem[idx];
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.data = rdata_q;

	// request held unchanged until its ack
	assert property (@(posedge clk_cpu) disable iff (rst_i)
		req_i.cyc && req_i.stb && !rsp_o.ack |=> req_i.stb && $stable(req_i.addr))
		else $error("ram request changed before its ack");

endmodule

// ==== logic/wb_slave_decoder.sv ====
`timescale 1ns/1ns

module wb_slave_decoder (
	input  logic                clk_cpu,
	input  logic                rst_i,
	input  wb_bus_pkg::wb_req_t bus_req_i,
	output wb_bus_pkg::wb_rsp_t bus_rsp_o,
	output wb_bus_pkg::wb_req_t ram_req_o,
	input  wb_bus_pkg::wb_rsp_t ram_rsp_i,
	output wb_bus_pkg::wb_req_t dev_req_o,
	input  wb_bus_pkg::wb_rsp_t dev_rsp_i
);
	import wb_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int HI_W = ADDR_W + 2 - DEV_ADDR_BITS;

	logic ram_hit;
	logic dev_hit;
	logic none_stb;
	logic none_ack;

	assign ram_hit = (bus_req_i.addr[ADDR_W-1:RAM_ADDR_BITS] == '0);
	assign dev_hit = (bus_req_i.addr[ADDR_W-1 -: HI_W] == DEV_BASE_HI);
	assign none_stb = bus_req_i.cyc && bus_req_i.stb && !ram_hit && !dev_hit;

	always_comb begin
		ram_req_o = bus_req_i;
		ram_req_o.cyc = bus_req_i.cyc && ram_hit;
		ram_req_o.stb = bus_req_i.stb && ram_hit;
		dev_req_o = bus_req_i;
		dev_req_o.cyc = bus_req_i.cyc && dev_hit;
		dev_req_o.stb = bus_req_i.stb && dev_hit;
	end

	// unmapped space, acks once with zero
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			none_ack <= 1'b0;
		end else begin
			none_ack <= none_stb && !none_ack;
		end
	end

	always_comb begin
		if (ram_hit) begin
			bus_rsp_o = ram_rsp_i;
		end else if (dev_hit) begin
			bus_rsp_o = dev_rsp_i;
		end else begin
			bus_rsp_o.ack = none_ack;
			bus_rsp_o.data = '0;
		end
	end

	// the slave that acks is still the one selected
	assert property (@(posedge clk_cpu) disable iff (rst_i)
		(ram_rsp_i.ack || dev_rsp_i.ack || none_ack) |-> bus_rsp_o.ack)
		else $error("slave ack lost in the response mux");

endmodule

// ==== logic/wb_arbiter.sv ====
`timescale 1ns/1ns

module wb_arbiter (
	input  logic                clk_cpu,
	input  logic                rst_i,
	input  wb_bus_pkg::wb_req_t m0_req_i,
	input  wb_bus_pkg::wb_req_t m1_req_i,
	output wb_bus_pkg::wb_rsp_t m0_rsp_o,
	output wb_bus_pkg::wb_rsp_t m1_rsp_o,
	output wb_bus_pkg::wb_req_t bus_req_o,
	input  wb_bus_pkg::wb_rsp_t bus_rsp_i
);

	logic gnt_valid;
	logic gnt_id;
	logic gnt_cyc;

	// cyc of whoever holds the bus
	assign gnt_cyc = gnt_id ? m1_req_i.cyc : m0_req_i.cyc;

	// master 0 (display fetch) wins when both ask
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			gnt_valid <= 1'b0;
			gnt_id <= 1'b0;
		end else if (!gnt_valid) begin
			if (m0_req_i.cyc) begin
				gnt_valid <= 1'b1;
				gnt_id <= 1'b0;
			end else if (m1_req_i.cyc) begin
				gnt_valid <= 1'b1;
				gnt_id <= 1'b1;
			end
		end else if (!gnt_cyc) begin
			// cycle over, bus free next cycle
			gnt_valid <= 1'b0;
		end
	end

	always_comb begin
		bus_req_o = '0;
		if (gnt_valid) begin
			bus_req_o = gnt_id ? m1_req_i : m0_req_i;
		end
	end

	// response back to the granted master only
	always_comb begin
		m0_rsp_o = '0;
		m1_rsp_o = '0;
		if (gnt_valid && !gnt_id) begin
			m0_rsp_o = bus_rsp_i;
		end
		if (gnt_valid && gnt_id) begin
			m1_rsp_o = bus_rsp_i;
		end
	end

	// slave ack belongs to the master granted when the slave saw stb
	assert property (@(posedge clk_cpu) disable iff (rst_i)
		bus_rsp_i.ack |-> gnt_valid && $past(gnt_valid) && $stable(gnt_id))
		else $error("ack returned after grant changed");

endmodule

// ==== logic/soc_map_pkg.sv ====
package soc_map_pkg;

	// on-chip RAM at word address 0
	localparam int RAM_ADDR_BITS = 10;

	// device region, top byte-address bits fixed
	localparam int DEV_ADDR_BITS = 16;
	localparam logic [15:0] DEV_BASE_HI = 16'hFFFF;

	// 256 bytes per device slot
	localparam int SLOT_BITS = 8;

	// slot numbers
	localparam int SLOT_BOARD = 2;

	// board register indices, in words
	localparam int REG_SWITCH = 0;
	localparam int REG_LED = 1;
	localparam int REG_IRQ_STATUS = 2;
	localparam int REG_IRQ_ENABLE = 3;

	// board i/o widths
	localparam int SWITCH_W = 16;
	localparam int LED_W = 16;

endpackage

// ==== logic/wb_bus_pkg.sv ====
package wb_bus_pkg;

	localparam int DATA_W = 32;
	// word address, byte address bits 31:2
	localparam int ADDR_W = 30;
	localparam int SEL_W = 4;
	// register index inside one device slot
	localparam int REG_ADDR_W = 6;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} wb_req_t;

	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] data;
	} wb_rsp_t;

	// peripheral side of the device adapter
	typedef struct packed {
		logic                  cs;
		logic                  we;
		logic [SEL_W-1:0]      sel;
		logic [REG_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     data;
	} dev_req_t;

endpackage
